//--- monitor_pkg.sv
`default_nettype none

package monitor_pkg;

    // uart bit period in clk_in cycles
    localparam int CLKS_PER_BIT = 8;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

    // command bytes from the host
    localparam logic [7:0] CMD_WRITE   = 8'h30;
    localparam logic [7:0] CMD_READ    = 8'h31;

    // sent back for anything else
    localparam logic [7:0] REPLY_ERROR = 8'h3F;

    // external word-addressed sram
    localparam int SRAM_ADDR_W = 20;
    localparam int SRAM_DATA_W = 32;

    // strobe low time per access
    localparam int SRAM_WAIT_CYCLES = 2;
    localparam int WAIT_CNT_W       = $clog2(SRAM_WAIT_CYCLES + 1);

endpackage

`default_nettype wire

//--- mem_bus_if.sv
`default_nettype none
`timescale 1ns/1ns

interface mem_bus_if
    import monitor_pkg::*;
();

    logic                   req;
    logic                   we;
    logic [SRAM_ADDR_W-1:0] addr;
    logic [SRAM_DATA_W-1:0] wdata;
    logic [SRAM_DATA_W-1:0] rdata;
    // single-cycle completion pulse
    logic                   ack;

    modport engine (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport port (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

//--- uart_rx.sv
`default_nettype none
`timescale 1ns/1ns

module uart_rx
    import monitor_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  logic       rxd,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    logic                 rx_meta;
    logic                 rx_sync;
    logic                 active;
    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_idx;
    logic [7:0]           shift;
    logic                 sample;

    assign sample = active && (clk_cnt == '0);

    // two-flop synchronizer that idles high
    always_ff @(posedge clk_in) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active     <= 1'b0;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (!active) begin
                if (!rx_sync) begin
                    // first sample lands mid start bit
                    active  <= 1'b1;
                    clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_idx <= '0;
                end
            end else if (sample) begin
                clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
                bit_idx <= bit_idx + 4'd1;
                if (bit_idx == 4'd0 && rx_sync) begin
                    // glitch rather than a real start bit
                    active <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    active     <= 1'b0;
                    byte_valid <= rx_sync;
                end
            end else begin
                clk_cnt <= clk_cnt - 1'b1;
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk_in) begin
        if (sample && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (sample && bit_idx == 4'd9) begin
            byte_data <= shift;
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
`default_nettype none
`timescale 1ns/1ns

module uart_tx
    import monitor_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       txd,
    output logic       busy
);

    logic [CLK_CNT_W-1:0] clk_cnt;
    logic [3:0]           bit_cnt;
    // data bits then the stop bit
    logic [8:0]           shift;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            txd     <= 1'b1;
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            if (tx_start) begin
                txd     <= 1'b0;
                busy    <= 1'b1;
                clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
                bit_cnt <= '0;
            end
        end else if (clk_cnt == '0) begin
            clk_cnt <= CLK_CNT_W'(CLKS_PER_BIT - 1);
            if (bit_cnt == 4'd9) begin
                // stop bit done and line already high
                busy <= 1'b0;
            end else begin
                txd     <= shift[0];
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            clk_cnt <= clk_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!busy && tx_start) begin
            shift <= {1'b1, tx_data};
        end else if (busy && clk_cnt == '0) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

`default_nettype wire

//--- monitor_engine.sv
`default_nettype none
`timescale 1ns/1ns

module monitor_engine
    import monitor_pkg::*;
(
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    mem_bus_if.engine  mem,
    output logic [7:0] tx_data,
    output logic       tx_start,
    input  logic       tx_busy
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_ADDR,
        S_COUNT,
        S_DATA,
        S_MEM_WR,
        S_MEM_RD,
        S_SEND,
        S_ERROR,
        S_DRAIN
    } state_t;

    state_t      state;
    logic [1:0]  byte_cnt;
    logic [31:0] count;
    logic [31:0] word;
    logic        buf_valid;
    logic [7:0]  buf_data;

    logic        in_valid;
    logic [7:0]  in_data;
    logic        consume;
    logic        buf_load;
    logic [31:0] word_next;
    logic        tx_ready;
    logic        last_byte;
    logic        last_word;

    // a held byte goes ahead of a fresh one
    assign in_valid  = buf_valid || byte_valid;
    assign in_data   = buf_valid ? buf_data : byte_data;
    assign consume   = in_valid && (state inside {S_IDLE, S_ADDR, S_COUNT, S_DATA});
    assign buf_load  = byte_valid && (state == S_MEM_WR || (consume && buf_valid));
    // little-endian assembly
    assign word_next = {in_data, word[31:8]};
    // busy lags tx_start by one cycle
    assign tx_ready  = !tx_busy && !tx_start;
    assign last_byte = (byte_cnt == 2'd3);
    assign last_word = (count == 32'd1);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state     <= S_IDLE;
            byte_cnt  <= '0;
            count     <= '0;
            mem.req   <= 1'b0;
            mem.we    <= 1'b0;
            tx_start  <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (buf_load) begin
                buf_valid <= 1'b1;
            end else if (consume) begin
                buf_valid <= 1'b0;
            end
            case (state)
                S_IDLE: if (consume) begin
                    byte_cnt <= '0;
                    if (in_data == CMD_WRITE) begin
                        mem.we <= 1'b1;
                        state  <= S_ADDR;
                    end else if (in_data == CMD_READ) begin
                        mem.we <= 1'b0;
                        state  <= S_ADDR;
                    end else begin
                        state <= S_ERROR;
                    end
                end
                S_ADDR: if (consume) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (last_byte) state <= S_COUNT;
                end
                S_COUNT: if (consume) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (last_byte) begin
                        count <= word_next;
                        // zero count is a silent no-op
                        if (word_next == 32'd0) begin
                            state <= S_IDLE;
                        end else if (mem.we) begin
                            state <= S_DATA;
                        end else begin
                            mem.req <= 1'b1;
                            state   <= S_MEM_RD;
                        end
                    end
                end
                S_DATA: if (consume) begin
                    byte_cnt <= byte_cnt + 2'd1;
                    if (last_byte) begin
                        mem.req <= 1'b1;
                        state   <= S_MEM_WR;
                    end
                end
                S_MEM_WR: if (mem.ack) begin
                    mem.req <= 1'b0;
                    count   <= count - 32'd1;
                    state   <= last_word ? S_IDLE : S_DATA;
                end
                S_MEM_RD: if (mem.ack) begin
                    mem.req <= 1'b0;
                    state   <= S_SEND;
                end
                S_SEND: if (tx_ready) begin
                    tx_start <= 1'b1;
                    byte_cnt <= byte_cnt + 2'd1;
                    if (last_byte) begin
                        count <= count - 32'd1;
                        if (last_word) begin
                            state <= S_DRAIN;
                        end else begin
                            mem.req <= 1'b1;
                            state   <= S_MEM_RD;
                        end
                    end
                end
                S_ERROR: if (tx_ready) begin
                    tx_start <= 1'b1;
                    state    <= S_DRAIN;
                end
                // hold until the last reply byte is out
                S_DRAIN: if (tx_ready) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (buf_load) buf_data <= byte_data;
        case (state)
            S_ADDR: if (consume) begin
                word <= word_next;
                if (last_byte) mem.addr <= word_next[SRAM_ADDR_W-1:0];
            end
            S_COUNT: if (consume) word <= word_next;
            S_DATA: if (consume) begin
                word <= word_next;
                if (last_byte) mem.wdata <= word_next;
            end
            S_MEM_WR: if (mem.ack) mem.addr <= mem.addr + 1'b1;
            S_MEM_RD: if (mem.ack) word <= mem.rdata;
            S_SEND: if (tx_ready) begin
                tx_data <= word[7:0];
                word    <= {8'h00, word[31:8]};
                if (last_byte) mem.addr <= mem.addr + 1'b1;
            end
            S_ERROR: tx_data <= REPLY_ERROR;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- sram_port.sv
`default_nettype none
`timescale 1ns/1ns

module sram_port
    import monitor_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset,
    mem_bus_if.port                mem,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output logic [SRAM_DATA_W-1:0] sram_dq_out,
    input  logic [SRAM_DATA_W-1:0] sram_dq_in,
    output logic                   sram_dq_oe,
    output logic                   sram_ce_n,
    output logic                   sram_oe_n,
    output logic                   sram_we_n
);

    logic                  active;
    logic [WAIT_CNT_W-1:0] wait_cnt;
    logic                  start;
    logic                  last_low;

    // req is still high in the ack cycle
    assign start    = mem.req && !active && !mem.ack;
    assign last_low = active && (wait_cnt == '0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            active     <= 1'b0;
            wait_cnt   <= '0;
            mem.ack    <= 1'b0;
            sram_ce_n  <= 1'b1;
            sram_oe_n  <= 1'b1;
            sram_we_n  <= 1'b1;
            sram_dq_oe <= 1'b0;
        end else begin
            mem.ack <= 1'b0;
            if (start) begin
                active     <= 1'b1;
                wait_cnt   <= WAIT_CNT_W'(SRAM_WAIT_CYCLES - 1);
                sram_ce_n  <= 1'b0;
                sram_oe_n  <= mem.we;
                sram_we_n  <= !mem.we;
                sram_dq_oe <= mem.we;
            end else if (last_low) begin
                active     <= 1'b0;
                mem.ack    <= 1'b1;
                sram_ce_n  <= 1'b1;
                sram_oe_n  <= 1'b1;
                sram_we_n  <= 1'b1;
                sram_dq_oe <= 1'b0;
            end else if (active) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            sram_addr   <= mem.addr;
            sram_dq_out <= mem.wdata;
        end
        // sample at the end of the last low cycle
        if (last_low && sram_we_n) begin
            mem.rdata <= sram_dq_in;
        end
    end

endmodule

`default_nettype wire

//--- monitor_top.sv
`default_nettype none
`timescale 1ns/1ns

module monitor_top
    import monitor_pkg::*;
(
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   rxd,
    output logic                   txd,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output logic [SRAM_DATA_W-1:0] sram_dq_out,
    input  logic [SRAM_DATA_W-1:0] sram_dq_in,
    output logic                   sram_dq_oe,
    output logic                   sram_ce_n,
    output logic                   sram_oe_n,
    output logic                   sram_we_n
);

    logic [7:0] byte_data;
    logic       byte_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;

    mem_bus_if mem_bus ();

    uart_rx u_rx (
        .clk_in     (clk_in),
        .reset      (reset),
        .rxd        (rxd),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    monitor_engine u_engine (
        .clk_in     (clk_in),
        .reset      (reset),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .mem        (mem_bus.engine),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy)
    );

    sram_port u_sram (
        .clk_in      (clk_in),
        .reset       (reset),
        .mem         (mem_bus.port),
        .sram_addr   (sram_addr),
        .sram_dq_out (sram_dq_out),
        .sram_dq_in  (sram_dq_in),
        .sram_dq_oe  (sram_dq_oe),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_we_n   (sram_we_n)
    );

    uart_tx u_tx (
        .clk_in   (clk_in),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .txd      (txd),
        .busy     (tx_busy)
    );

endmodule

`default_nettype wire

//--- tb_sram_model.sv
`default_nettype none
`timescale 1ns/1ns

module tb_sram_model
    import monitor_pkg::*;
(
    input  logic [SRAM_ADDR_W-1:0] addr,
    input  logic [SRAM_DATA_W-1:0] din,
    output logic [SRAM_DATA_W-1:0] dout,
    input  logic                   ce_n,
    input  logic                   oe_n,
    input  logic                   we_n
);

    logic [SRAM_DATA_W-1:0] mem_array [0:(1 << SRAM_ADDR_W) - 1];

    // bus floats unless selected for a read
    assign dout = (!ce_n && !oe_n) ? mem_array[addr] : 'x;

    // addr and din hold past the end of a write strobe
    always @(posedge we_n) begin
        mem_array[addr] <= din;
    end

endmodule

`default_nettype wire

//--- tb_monitor.sv
`default_nettype none
`timescale 1ns/1ns

module tb_monitor
    import monitor_pkg::*;
();

    localparam int RX_TIMEOUT = 400;

    logic                   clk_in;
    logic                   reset;
    logic                   rxd;
    logic                   txd;
    logic [SRAM_ADDR_W-1:0] sram_addr;
    logic [SRAM_DATA_W-1:0] sram_dq_out;
    logic [SRAM_DATA_W-1:0] sram_dq_in;
    logic                   sram_dq_oe;
    logic                   sram_ce_n;
    logic                   sram_oe_n;
    logic                   sram_we_n;

    logic [31:0] lfsr_state;
    logic [31:0] expect_mem [logic [SRAM_ADDR_W-1:0]];
    int          tests;
    int          checks;
    int          errors;

    monitor_top UUT (
        .clk_in      (clk_in),
        .reset       (reset),
        .rxd         (rxd),
        .txd         (txd),
        .sram_addr   (sram_addr),
        .sram_dq_out (sram_dq_out),
        .sram_dq_in  (sram_dq_in),
        .sram_dq_oe  (sram_dq_oe),
        .sram_ce_n   (sram_ce_n),
        .sram_oe_n   (sram_oe_n),
        .sram_we_n   (sram_we_n)
    );

    tb_sram_model u_sram_model (
        .addr (sram_addr),
        .din  (sram_dq_out),
        .dout (sram_dq_in),
        .ce_n (sram_ce_n),
        .oe_n (sram_oe_n),
        .we_n (sram_we_n)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        int i;
        for (i = 0; i < 32; i++) begin
            w[i] = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
        return w;
    endfunction

    task automatic step_cycle();
        @(posedge clk_in);
        #5;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // data bus driven only while the write strobe is low
    always @(negedge clk_in) begin
        if (!reset && !sram_ce_n) begin
            check_value(32'(sram_dq_oe), 32'(!sram_we_n), "sram_dq_oe during an access");
        end
    end

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int i;
        // start bit, data lsb first, stop bit
        frame = {1'b1, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (CLKS_PER_BIT) step_cycle();
        end
    endtask

    task automatic send_word(input logic [31:0] w);
        int i;
        for (i = 0; i < 4; i++) begin
            send_byte(w[8*i +: 8]);
        end
    endtask

    task automatic recv_byte(output logic [7:0] data);
        int wait_cnt;
        int i;
        data = 8'h00;
        wait_cnt = 0;
        while (txd !== 1'b0 && wait_cnt < RX_TIMEOUT) begin
            step_cycle();
            wait_cnt++;
        end
        if (txd !== 1'b0) begin
            errors++;
            $display("no start bit on txd within %0d cycles at time %0t", RX_TIMEOUT, $time);
        end else begin
            // middle of the start bit
            repeat (CLKS_PER_BIT / 2) step_cycle();
            for (i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) step_cycle();
                data[i] = txd;
            end
            repeat (CLKS_PER_BIT) step_cycle();
            check_value(32'(txd), 32'd1, "stop bit on txd");
        end
    endtask

    // counts cycles with any line out of its idle level
    task automatic check_quiet(input int cycles, input string what);
        int active_cycles;
        int i;
        active_cycles = 0;
        for (i = 0; i < cycles; i++) begin
            if (!txd || !sram_ce_n || !sram_oe_n || !sram_we_n || sram_dq_oe) begin
                active_cycles++;
            end
            step_cycle();
        end
        check_value(32'(active_cycles), 32'd0, what);
    endtask

    task automatic write_words(input logic [SRAM_ADDR_W-1:0] addr, input int count);
        logic [31:0] w;
        int i;
        send_byte(CMD_WRITE);
        send_word(32'(addr));
        send_word(32'(count));
        for (i = 0; i < count; i++) begin
            w = random_word();
            expect_mem[addr + SRAM_ADDR_W'(i)] = w;
            send_word(w);
        end
    endtask

    task automatic read_check(input logic [SRAM_ADDR_W-1:0] addr, input int count);
        logic [7:0]             got;
        logic [31:0]            exp;
        logic [SRAM_ADDR_W-1:0] a;
        int i;
        int b;
        send_byte(CMD_READ);
        send_word(32'(addr));
        send_word(32'(count));
        for (i = 0; i < count; i++) begin
            a = addr + SRAM_ADDR_W'(i);
            exp = expect_mem[a];
            for (b = 0; b < 4; b++) begin
                recv_byte(got);
                check_value(32'(got), 32'(exp[8*b +: 8]),
                            $sformatf("reply byte %0d of word %h", b, a));
            end
            check_value(u_sram_model.mem_array[a], exp, $sformatf("sram word %h", a));
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic check_idle_after_reset();
        int start_errors;
        start_errors = errors;
        check_quiet(50, "lines active after reset");
        report_test("idle after reset", start_errors);
    endtask

    task automatic write_then_read_back();
        int start_errors;
        start_errors = errors;
        write_words(20'h00100, 4);
        read_check(20'h00100, 4);
        report_test("write and read back", start_errors);
    endtask

    task automatic reject_unknown_command();
        logic [7:0] got;
        int start_errors;
        start_errors = errors;
        send_byte(8'h34);
        recv_byte(got);
        check_value(32'(got), 32'(REPLY_ERROR), "reply to unknown command");
        // a second byte would show up here
        check_quiet(200, "activity after error reply");
        read_check(20'h00100, 1);
        report_test("unknown command", start_errors);
    endtask

    task automatic skip_zero_count();
        int start_errors;
        start_errors = errors;
        send_byte(CMD_WRITE);
        send_word(32'h0000_0200);
        send_word(32'd0);
        check_quiet(400, "activity after zero count write");
        write_words(20'h00200, 1);
        read_check(20'h00200, 1);
        report_test("zero count", start_errors);
    endtask

    task automatic keep_ranges_apart();
        int start_errors;
        start_errors = errors;
        write_words(20'h00400, 3);
        // crosses a carry into bit 16
        write_words(20'h0FFFE, 3);
        read_check(20'h0FFFE, 3);
        read_check(20'h00400, 3);
        report_test("two ranges", start_errors);
    endtask

    initial begin
        reset = 1'b1;
        rxd = 1'b1;
        lfsr_state = 32'd87664;
        tests = 0;
        checks = 0;
        errors = 0;
        repeat (10) step_cycle();
        reset = 1'b0;

        check_idle_after_reset();
        write_then_read_back();
        reject_unknown_command();
        skip_zero_count();
        keep_ranges_apart();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
monitor_pkg.sv
mem_bus_if.sv
uart_rx.sv
uart_tx.sv
monitor_engine.sv
sram_port.sv
monitor_top.sv
tb_sram_model.sv
tb_monitor.sv

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_monitor -o tb_monitor
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_monitor > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
